// File: Makefile
VERILATOR ?= verilator
FILELIST  ?= fifo_capture_top.f
TOP       ?= tb_fifo_capture
LINT_TOP  ?= fifo_capture_top
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing

SOURCES := $(shell grep '\.sv$$' $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

$(BUILD)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD)

sim: $(BUILD)/V$(TOP)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	elif ! grep -q "Testbench passed" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: capture_ctrl/capture_fsm.sv
`timescale 1ns/1ps

module capture_fsm (
    input  logic                     adc_sampleclk,
    input  logic                     fifo_rst,
    input  logic                     arm_i,
    input  logic                     capture_go_i,
    input  capture_pkg::presample_t  presample_i,
    input  capture_pkg::count_t      max_samples_i,
    input  capture_pkg::downsample_t downsample_i,
    output logic                     sample_wr_o,
    output logic                     drop_oldest_o,
    output logic                     drain_en_o,
    output logic                     flush_o,
    input  logic                     packer_idle_i,
    input  logic                     buffer_empty_i,
    output logic                     capture_done_o,
    output logic                     presamp_error_o,
    output logic                     downsample_error_o
);

    capture_pkg::capture_state_e state;
    logic                        arm_r;
    logic                        arm_r2;
    logic                        go_r;
    capture_pkg::presample_t     pre_cnt;
    logic [1:0]                  pre_mod3;
    capture_pkg::count_t         sample_cnt;
    logic [1:0]                  cnt_mod3;
    capture_pkg::downsample_t    ds_cnt;
    capture_pkg::downsample_t    ds_eff;
    logic                        window_set;
    logic                        waiting;
    logic                        trig;
    logic                        keep;
    capture_pkg::count_t         next_cnt;
    logic [1:0]                  base_mod3;
    logic [1:0]                  next_mod3;
    logic                        stop;

    assign window_set = (presample_i != '0);
    assign ds_eff     = window_set ? '0 : downsample_i; // no decimation with presamples
    assign waiting    = (state == capture_pkg::st_presamp_filling) ||
                        (state == capture_pkg::st_presamp_full);
    assign trig       = capture_go_i & ~go_r & waiting;
    assign keep       = (ds_cnt == ds_eff);

    // count after the sample pushed in this cycle
    assign next_cnt  = (trig ? capture_pkg::count_t'(pre_cnt) : sample_cnt) + 32'd1;
    assign base_mod3 = trig ? pre_mod3 : cnt_mod3;
    assign next_mod3 = (base_mod3 == 2'd2) ? 2'd0 : base_mod3 + 2'd1;
    assign stop      = (next_cnt >= max_samples_i) && (next_mod3 == 2'd0);

    always_comb begin
        sample_wr_o   = 1'b0;
        drop_oldest_o = 1'b0;
        case (state)
            capture_pkg::st_presamp_filling: sample_wr_o = 1'b1;
            capture_pkg::st_presamp_full: begin
                sample_wr_o   = window_set | trig;
                drop_oldest_o = window_set & ~trig; // slide the window
            end
            capture_pkg::st_triggered: sample_wr_o = keep;
            default: ;
        endcase
    end

    // head leaves on the trigger cycle too
    assign drain_en_o = (state == capture_pkg::st_triggered) ||
                        (state == capture_pkg::st_done) || trig;

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            arm_r   <= 1'b0;
            arm_r2  <= 1'b0;
            flush_o <= 1'b0;
        end else begin
            arm_r   <= arm_i;
            arm_r2  <= arm_r;
            flush_o <= arm_r & ~arm_r2; // arm edge, two cycles late
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            state              <= capture_pkg::st_idle;
            go_r               <= 1'b0;
            pre_cnt            <= '0;
            pre_mod3           <= 2'd0;
            sample_cnt         <= '0;
            cnt_mod3           <= 2'd0;
            ds_cnt             <= '0;
            capture_done_o     <= 1'b0;
            presamp_error_o    <= 1'b0;
            downsample_error_o <= 1'b0;
        end else if (flush_o) begin
            // a level already high on go counts as an edge after arming
            go_r               <= 1'b0;
            state              <= window_set ? capture_pkg::st_presamp_filling
                                             : capture_pkg::st_presamp_full;
            pre_cnt            <= '0;
            pre_mod3           <= 2'd0;
            ds_cnt             <= '0;
            capture_done_o     <= 1'b0;
            presamp_error_o    <= 1'b0;
            downsample_error_o <= window_set && (downsample_i != '0);
        end else begin
            go_r <= capture_go_i;
            if (trig) begin
                if (state == capture_pkg::st_presamp_filling)
                    presamp_error_o <= 1'b1; // window not yet full
                sample_cnt <= next_cnt;
                cnt_mod3   <= next_mod3;
                ds_cnt     <= '0;
                state      <= stop ? capture_pkg::st_done : capture_pkg::st_triggered;
            end else begin
                case (state)
                    capture_pkg::st_presamp_filling: begin
                        pre_cnt  <= pre_cnt + 15'd1;
                        pre_mod3 <= (pre_mod3 == 2'd2) ? 2'd0 : pre_mod3 + 2'd1;
                        if (pre_cnt + 15'd1 == presample_i)
                            state <= capture_pkg::st_presamp_full;
                    end
                    capture_pkg::st_triggered: begin
                        if (keep) begin
                            ds_cnt     <= '0;
                            sample_cnt <= next_cnt;
                            cnt_mod3   <= next_mod3;
                            if (stop)
                                state <= capture_pkg::st_done;
                        end else begin
                            ds_cnt <= ds_cnt + 13'd1;
                        end
                    end
                    capture_pkg::st_done: begin
                        if (buffer_empty_i && packer_idle_i)
                            capture_done_o <= 1'b1; // held until next arm
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: capture_ctrl/presample_buffer.sv
`timescale 1ns/1ps

module presample_buffer #(
    parameter int PRESAMPLE_DEPTH = 64
) (
    input  logic                 adc_sampleclk,
    input  logic                 fifo_rst,
    input  logic                 flush_i,
    input  logic                 sample_wr_i,
    input  capture_pkg::sample_t sample_i,
    input  logic                 drop_oldest_i,
    input  logic                 drain_en_i,
    input  logic                 store_full_i,
    output logic                 sample_valid_o,
    output capture_pkg::sample_t sample_o,
    output logic                 empty_o,
    output logic                 overflow_o
);

    localparam int AW = $clog2(PRESAMPLE_DEPTH);

    capture_pkg::sample_t mem [PRESAMPLE_DEPTH];
    logic [AW-1:0]        wr_ptr;
    logic [AW-1:0]        rd_ptr;
    logic [AW:0]          count;
    logic                 full;
    logic                 spill;
    logic                 spill_start;
    logic                 pop;
    logic                 push;

    assign full    = (count == (AW+1)'(PRESAMPLE_DEPTH));
    assign empty_o = (count == '0);

    // once the buffer is full behind a full store it spills onward, whole words
    // are then lost in the store and the capture can still finish
    assign spill_start    = sample_wr_i & full & drain_en_i & store_full_i & ~spill;
    assign sample_valid_o = drain_en_i & ~empty_o & (~store_full_i | spill | spill_start);
    assign sample_o       = mem[rd_ptr];

    assign pop  = sample_valid_o | (drop_oldest_i & ~empty_o);
    assign push = sample_wr_i & (~full | pop);

    always_ff @(posedge adc_sampleclk) begin
        if (push)
            mem[wr_ptr] <= sample_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            spill      <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(PRESAMPLE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(PRESAMPLE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (spill_start)
                spill <= 1'b1;
            if ((sample_wr_i && !push) || spill_start)
                overflow_o <= 1'b1; // sticky until next arm
        end
    end

endmodule

// File: common/capture_pkg.sv
package capture_pkg;

    typedef logic [11:0] sample_t;     // one adc sample
    typedef logic [35:0] word_t;       // three samples, oldest in [35:24]
    typedef logic [7:0]  byte_t;       // readout byte
    typedef logic [31:0] count_t;      // sample limit and counter
    typedef logic [14:0] presample_t;  // presample window depth
    typedef logic [12:0] downsample_t; // keep every (n+1)-th sample

    // [2] presample error, [1] downsample config error, [0] overflow
    typedef logic [2:0]  error_t;

    typedef enum logic [2:0] {
        st_idle,
        st_presamp_filling,
        st_presamp_full,
        st_triggered,
        st_done
    } capture_state_e;

    localparam int SAMPLES_PER_WORD = 3;

endpackage

// File: fifo_capture_top.f
common/capture_pkg.sv
capture_ctrl/capture_fsm.sv
capture_ctrl/presample_buffer.sv
source/sample_packer.sv
readout/sample_store.sv
readout/byte_serializer.sv
source/fifo_capture_top.sv
verification/tb_fifo_capture.sv

// File: readout/byte_serializer.sv
`timescale 1ns/1ps

module byte_serializer (
    input  logic               adc_sampleclk,
    input  logic               fifo_rst,
    input  logic               flush_i,
    input  logic               low_res_i,
    input  logic               capture_done_i,
    input  logic               word_valid_i,
    input  capture_pkg::word_t word_i,
    output logic               word_rd_o,
    input  logic               read_en_i,
    output capture_pkg::byte_t read_data_o,
    output logic               empty_o
);

    logic [3:0]         idx;   // byte position within word pair or word
    logic [3:0]         nib_r; // low nibble of the first word of a pair
    logic               pending;
    logic               last_of_word;
    logic               pad;
    logic               consume;
    capture_pkg::byte_t byte_mux;

    // odd word count at the end, fifth byte closes with a zero nibble
    assign pad = ~low_res_i & (idx == 4'd4) & ~word_valid_i & capture_done_i;

    assign pending      = word_valid_i | pad;
    assign empty_o      = ~pending;
    assign consume      = read_en_i & pending;
    assign last_of_word = low_res_i ? (idx == 4'd2) : ((idx == 4'd3) || (idx == 4'd8));
    assign word_rd_o    = consume & word_valid_i & last_of_word;

    always_comb begin
        byte_mux = '0;
        if (low_res_i) begin
            case (idx)
                4'd0:    byte_mux = word_i[35:28];
                4'd1:    byte_mux = word_i[23:16];
                4'd2:    byte_mux = word_i[11:4];
                default: byte_mux = '0;
            endcase
        end else begin
            case (idx)
                4'd0:    byte_mux = word_i[35:28];
                4'd1:    byte_mux = word_i[27:20];
                4'd2:    byte_mux = word_i[19:12];
                4'd3:    byte_mux = word_i[11:4];
                4'd4:    byte_mux = {nib_r, pad ? 4'h0 : word_i[35:32]};
                4'd5:    byte_mux = word_i[31:24];
                4'd6:    byte_mux = word_i[23:16];
                4'd7:    byte_mux = word_i[15:8];
                4'd8:    byte_mux = word_i[7:0];
                default: byte_mux = '0;
            endcase
        end
    end

    always_ff @(posedge adc_sampleclk) begin
        if (consume && !low_res_i && idx == 4'd3)
            nib_r <= word_i[3:0];
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst) begin
            idx         <= 4'd0;
            read_data_o <= '0;
        end else if (flush_i) begin
            idx <= 4'd0;
        end else if (consume) begin
            read_data_o <= byte_mux;
            if ((low_res_i && idx == 4'd2) || idx == 4'd8 || pad)
                idx <= 4'd0;
            else
                idx <= idx + 4'd1;
        end
    end

endmodule

// File: readout/sample_store.sv
`timescale 1ns/1ps

module sample_store #(
    parameter int STORE_DEPTH = 256
) (
    input  logic               adc_sampleclk,
    input  logic               fifo_rst,
    input  logic               flush_i,
    input  logic               word_wr_i,
    input  capture_pkg::word_t word_i,
    input  logic               word_rd_i,
    output logic               word_valid_o,
    output capture_pkg::word_t word_o,
    output logic               full_o,
    output logic               overflow_o
);

    localparam int AW = $clog2(STORE_DEPTH);

    capture_pkg::word_t mem [STORE_DEPTH];
    logic [AW-1:0]      wr_ptr;
    logic [AW-1:0]      rd_ptr;
    logic [AW:0]        count;
    logic               push;
    logic               pop;

    assign full_o       = (count == (AW+1)'(STORE_DEPTH));
    assign word_valid_o = (count != '0);
    assign word_o       = mem[rd_ptr];

    assign push = word_wr_i & ~full_o; // write into a full store is lost
    assign pop  = word_rd_i & word_valid_o;

    always_ff @(posedge adc_sampleclk) begin
        if (push)
            mem[wr_ptr] <= word_i;
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            overflow_o <= 1'b0;
        end else begin
            if (push)
                wr_ptr <= (wr_ptr == AW'(STORE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= (rd_ptr == AW'(STORE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            if (push && !pop)
                count <= count + 1'b1;
            else if (pop && !push)
                count <= count - 1'b1;
            if (word_wr_i && full_o)
                overflow_o <= 1'b1;
        end
    end

endmodule

// File: source/fifo_capture_top.sv
`timescale 1ns/1ps

module fifo_capture_top #(
    parameter int PRESAMPLE_DEPTH = 64,
    parameter int STORE_DEPTH     = 256
) (
    input  logic                     adc_sampleclk,
    input  logic                     fifo_rst,
    input  capture_pkg::sample_t     adc_data_i,
    input  logic                     arm_i,
    input  logic                     capture_go_i,
    input  capture_pkg::presample_t  presample_i,
    input  capture_pkg::count_t      max_samples_i,
    input  capture_pkg::downsample_t downsample_i,
    input  logic                     low_res_i,
    input  logic                     read_en_i,
    output capture_pkg::byte_t       read_data_o,
    output logic                     empty_o,
    output logic                     capture_done_o,
    output capture_pkg::error_t      error_stat_o
);

    logic                 sample_wr;
    logic                 drop_oldest;
    logic                 drain_en;
    logic                 flush;
    logic                 buffer_empty;
    logic                 buffer_overflow;
    logic                 sample_valid;
    capture_pkg::sample_t sample_data;
    logic                 packer_idle;
    logic                 word_wr;
    capture_pkg::word_t   word_data;
    logic                 store_full;
    logic                 store_overflow;
    logic                 word_valid;
    capture_pkg::word_t   store_data;
    logic                 word_rd;
    logic                 presamp_error;
    logic                 downsample_error;

    assign error_stat_o = {presamp_error, downsample_error, buffer_overflow | store_overflow};

    capture_fsm u_capture_fsm (
        .adc_sampleclk      (adc_sampleclk),
        .fifo_rst           (fifo_rst),
        .arm_i              (arm_i),
        .capture_go_i       (capture_go_i),
        .presample_i        (presample_i),
        .max_samples_i      (max_samples_i),
        .downsample_i       (downsample_i),
        .sample_wr_o        (sample_wr),
        .drop_oldest_o      (drop_oldest),
        .drain_en_o         (drain_en),
        .flush_o            (flush),
        .packer_idle_i      (packer_idle),
        .buffer_empty_i     (buffer_empty),
        .capture_done_o     (capture_done_o),
        .presamp_error_o    (presamp_error),
        .downsample_error_o (downsample_error)
    );

    presample_buffer #(
        .PRESAMPLE_DEPTH (PRESAMPLE_DEPTH)
    ) u_presample_buffer (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .flush_i        (flush),
        .sample_wr_i    (sample_wr),
        .sample_i       (adc_data_i),
        .drop_oldest_i  (drop_oldest),
        .drain_en_i     (drain_en),
        .store_full_i   (store_full),
        .sample_valid_o (sample_valid),
        .sample_o       (sample_data),
        .empty_o        (buffer_empty),
        .overflow_o     (buffer_overflow)
    );

    sample_packer u_sample_packer (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .flush_i        (flush),
        .sample_valid_i (sample_valid),
        .sample_i       (sample_data),
        .word_wr_o      (word_wr),
        .word_o         (word_data),
        .idle_o         (packer_idle)
    );

    sample_store #(
        .STORE_DEPTH (STORE_DEPTH)
    ) u_sample_store (
        .adc_sampleclk (adc_sampleclk),
        .fifo_rst      (fifo_rst),
        .flush_i       (flush),
        .word_wr_i     (word_wr),
        .word_i        (word_data),
        .word_rd_i     (word_rd),
        .word_valid_o  (word_valid),
        .word_o        (store_data),
        .full_o        (store_full),
        .overflow_o    (store_overflow)
    );

    byte_serializer u_byte_serializer (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .flush_i        (flush),
        .low_res_i      (low_res_i),
        .capture_done_i (capture_done_o),
        .word_valid_i   (word_valid),
        .word_i         (store_data),
        .word_rd_o      (word_rd),
        .read_en_i      (read_en_i),
        .read_data_o    (read_data_o),
        .empty_o        (empty_o)
    );

endmodule

// File: source/sample_packer.sv
`timescale 1ns/1ps

module sample_packer (
    input  logic                 adc_sampleclk,
    input  logic                 fifo_rst,
    input  logic                 flush_i,
    input  logic                 sample_valid_i,
    input  capture_pkg::sample_t sample_i,
    output logic                 word_wr_o,
    output capture_pkg::word_t   word_o,
    output logic                 idle_o
);

    logic [1:0] slot; // samples held in the partial word

    assign idle_o = (slot == 2'd0);

    // oldest sample ends up in the top bits
    always_ff @(posedge adc_sampleclk) begin
        if (sample_valid_i)
            word_o <= {word_o[23:0], sample_i};
    end

    always_ff @(posedge adc_sampleclk) begin
        if (fifo_rst || flush_i) begin
            slot      <= 2'd0;
            word_wr_o <= 1'b0;
        end else begin
            word_wr_o <= 1'b0;
            if (sample_valid_i) begin
                if (slot == 2'(capture_pkg::SAMPLES_PER_WORD - 1)) begin
                    slot      <= 2'd0;
                    word_wr_o <= 1'b1; // word complete next cycle
                end else begin
                    slot <= slot + 2'd1;
                end
            end
        end
    end

endmodule

// File: verification/tb_fifo_capture.sv
`timescale 1ns/1ps

module tb_fifo_capture;

    // rough cycle counts per test, used for the run limit
    localparam int LEN_RESET     = 8;
    localparam int LEN_HIRES     = 80;
    localparam int LEN_LOWRES    = 80;
    localparam int LEN_STALL     = 200;
    localparam int LEN_ERRORS    = 120;
    localparam int LEN_OVERFLOW  = 1220;
    localparam int TIMEOUT_CYCLES = 4 * (LEN_RESET + LEN_HIRES + LEN_LOWRES + LEN_STALL +
                                         LEN_ERRORS + LEN_OVERFLOW) + 2000;

    logic                     adc_sampleclk;
    logic                     fifo_rst;
    capture_pkg::sample_t     adc_data_i;
    logic                     arm_i;
    logic                     capture_go_i;
    capture_pkg::presample_t  presample_i;
    capture_pkg::count_t      max_samples_i;
    capture_pkg::downsample_t downsample_i;
    logic                     low_res_i;
    logic                     read_en_i;
    capture_pkg::byte_t       read_data_o;
    logic                     empty_o;
    logic                     capture_done_o;
    capture_pkg::error_t      error_stat_o;

    capture_pkg::sample_t hist[$]; // adc sample seen at each rising edge
    int cyc = 0;
    int trig_cyc = 0;
    int cap_pre = 0;
    int cap_ds = 0;
    int cap_max = 0;
    bit cap_lowres = 1'b0;
    int checks = 0;
    int errors = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int err_before;

    fifo_capture_top #(
        .PRESAMPLE_DEPTH (64),
        .STORE_DEPTH     (256)
    ) dut_i (
        .adc_sampleclk  (adc_sampleclk),
        .fifo_rst       (fifo_rst),
        .adc_data_i     (adc_data_i),
        .arm_i          (arm_i),
        .capture_go_i   (capture_go_i),
        .presample_i    (presample_i),
        .max_samples_i  (max_samples_i),
        .downsample_i   (downsample_i),
        .low_res_i      (low_res_i),
        .read_en_i      (read_en_i),
        .read_data_o    (read_data_o),
        .empty_o        (empty_o),
        .capture_done_o (capture_done_o),
        .error_stat_o   (error_stat_o)
    );

    always #4 adc_sampleclk = ~adc_sampleclk;

    // sample history and run limit
    always @(posedge adc_sampleclk) begin
        hist.push_back(adc_data_i);
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYCLES) begin
            $display("ERROR t=%0t run stopped at the cycle limit of %0d", $time, cyc);
            $display("Testbench failed");
            $finish;
        end
    end

    task automatic drive_adc();
        forever begin
            @(negedge adc_sampleclk);
            adc_data_i = capture_pkg::sample_t'($urandom);
        end
    endtask

    task automatic check_val(input string name, input int actual, input int expected);
        checks++;
        assert (actual == expected) else begin
            errors++;
            $display("FAIL t=%0t %s expected=0x%0h actual=0x%0h", $time, name, expected, actual);
        end
    endtask

    task automatic report_error(input string what);
        errors++;
        $display("ERROR t=%0t %s", $time, what);
    endtask

    task automatic end_test(input string name, input int err_start);
        tests_run++;
        if (errors == err_start) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_start);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge adc_sampleclk);
    endtask

    // configuration is held from here through the capture
    task automatic arm_capture(input int pre, input int ds, input int max_s, input bit lowres);
        @(negedge adc_sampleclk);
        presample_i   = capture_pkg::presample_t'(pre);
        downsample_i  = capture_pkg::downsample_t'(ds);
        max_samples_i = capture_pkg::count_t'(max_s);
        low_res_i     = lowres;
        arm_i         = 1'b1;
        cap_pre       = pre;
        cap_ds        = ds;
        cap_max       = max_s;
        cap_lowres    = lowres;
        @(negedge adc_sampleclk);
        arm_i = 1'b0;
    endtask

    task automatic pulse_go(input int hold);
        capture_go_i = 1'b1;
        trig_cyc     = cyc; // index of the next rising edge
        repeat (hold) @(negedge adc_sampleclk);
        capture_go_i = 1'b0;
    endtask

    task automatic wait_done(input int limit);
        int n;
        n = 0;
        while (!capture_done_o && n < limit) begin
            @(negedge adc_sampleclk);
            n++;
        end
        checks++;
        assert (capture_done_o) else
            report_error($sformatf("capture_done_o did not rise within %0d cycles", limit));
    endtask

    // presamples plus trigger sample, rounded up to whole words
    function automatic int sample_total();
        int n;
        n = (cap_max > cap_pre + 1) ? cap_max : cap_pre + 1;
        return ((n + 2) / 3) * 3;
    endfunction

    function automatic int sample_at(input int i);
        int ds_eff;
        ds_eff = (cap_pre != 0) ? 0 : cap_ds; // no decimation with a window
        if (i < cap_pre)
            return int'(hist[trig_cyc - cap_pre + i]);
        return int'(hist[trig_cyc + (i - cap_pre) * (ds_eff + 1)]);
    endfunction

    // 12-bit samples as one msb-first bit stream, zero padded
    function automatic int hi_byte(input int j, input int n_samp);
        int pos;
        int val;
        int k;
        val = 0;
        for (k = 0; k < 8; k++) begin
            pos = 8 * j + k;
            val = val << 1;
            if (pos / 12 < n_samp)
                val = val | ((sample_at(pos / 12) >> (11 - pos % 12)) & 1);
        end
        return val;
    endfunction

    task automatic read_bytes(input bit stall);
        int n_samp;
        int n_bytes;
        int got;
        int exp_byte;
        bit pend;
        n_samp  = sample_total();
        n_bytes = cap_lowres ? n_samp : (3 * n_samp + 1) / 2;
        got     = 0;
        pend    = 1'b0;
        while (got < n_bytes) begin
            @(negedge adc_sampleclk);
            if (pend) begin
                exp_byte = cap_lowres ? ((sample_at(got) >> 4) & 8'hff) : hi_byte(got, n_samp);
                check_val("read_data_o", int'(read_data_o), exp_byte);
                got++;
            end
            if (got < n_bytes) begin
                read_en_i = stall ? ($urandom_range(3) != 0) : 1'b1;
                pend      = read_en_i && !empty_o; // consumed at the next edge
            end else begin
                read_en_i = 1'b0;
                pend      = 1'b0;
            end
        end
    endtask

    initial begin
        adc_sampleclk = 1'b0;
        fifo_rst      = 1'b1;
        adc_data_i    = '0;
        arm_i         = 1'b0;
        capture_go_i  = 1'b0;
        presample_i   = '0;
        max_samples_i = '0;
        downsample_i  = '0;
        low_res_i     = 1'b0;
        read_en_i     = 1'b0;
        void'($urandom(56));
        fork
            drive_adc();
        join_none
        repeat (4) @(posedge adc_sampleclk);
        @(negedge adc_sampleclk);
        fifo_rst = 1'b0;

        err_before = errors;
        @(negedge adc_sampleclk);
        check_val("empty_o", int'(empty_o), 1);
        check_val("capture_done_o", int'(capture_done_o), 0);
        check_val("error_stat_o", int'(error_stat_o), 0);
        check_val("read_data_o", int'(read_data_o), 0);
        end_test("reset state", err_before);

        err_before = errors;
        arm_capture(0, 0, 30, 1'b0);
        wait_cycles(4);
        pulse_go(1);
        read_bytes(1'b0);
        wait_done(200);
        check_val("empty_o", int'(empty_o), 1);
        check_val("error_stat_o", int'(error_stat_o), 0);
        end_test("high resolution readout", err_before);

        err_before = errors;
        arm_capture(10, 0, 31, 1'b1);
        wait_cycles(14);
        pulse_go(1);
        wait_done(200);
        read_bytes(1'b0);
        check_val("empty_o", int'(empty_o), 1);
        end_test("presample window low resolution", err_before);

        err_before = errors;
        arm_capture(0, 2, 33, 1'b0);
        wait_cycles(4);
        pulse_go(1);
        read_bytes(1'b1);
        wait_done(300);
        check_val("empty_o", int'(empty_o), 1);
        end_test("downsample with read stalls", err_before);

        err_before = errors;
        arm_capture(8, 3, 30, 1'b0);
        wait_cycles(4);
        check_val("error_stat_o[1]", int'(error_stat_o[1]), 1);
        arm_capture(20, 0, 30, 1'b0);
        pulse_go(6); // trigger before the window fills
        wait_done(300);
        check_val("error_stat_o", int'(error_stat_o), 4);
        arm_capture(0, 0, 30, 1'b0);
        wait_cycles(4);
        check_val("error_stat_o", int'(error_stat_o), 0);
        check_val("capture_done_o", int'(capture_done_o), 0);
        end_test("error flags", err_before);

        err_before = errors;
        arm_capture(0, 0, 1200, 1'b0);
        wait_cycles(4);
        pulse_go(1);
        wait_done(3000);
        check_val("error_stat_o", int'(error_stat_o), 1);
        end_test("overflow without reading", err_before);

        $display("summary: %0d tests, %0d with errors, %0d checks, %0d errors",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
